/* files.f */
hdl/csr_pkg.sv
hdl/trap_pkg.sv
hdl/csr_counter64.sv
hdl/irq_ctrl.sv
hdl/trap_ctrl.sv
hdl/csr_bank.sv
verif/csr_bank_asserts.sv
verif/csr_bank_tb.sv

/* hdl/csr_bank.sv */
//////////////////////////////////////////////////////////////////////
// Machine-mode CSR bank top: decodes single-cycle CSR accesses,
// applies write/set/clear with per-register masks and serves reads
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module csr_bank (
    input  logic                       clk,
    input  logic                       reset,
    input  csr_pkg::csr_access_t       access_i,
    input  trap_pkg::trap_req_t        trap_i,
    input  logic [csr_pkg::XLEN-1:0]   irq_i,
    output logic [csr_pkg::XLEN-1:0]   rdata_o,
    output logic                       interrupt_pending_o,
    output trap_pkg::priv_e            privilege_o,
    output logic [csr_pkg::XLEN-1:0]   mepc_o,
    output logic [csr_pkg::XLEN-1:0]   mtvec_o
);

    localparam int W = csr_pkg::XLEN;

    logic [W-1:0]        mie_q, mtvec_q, mscratch_q;
    logic [W-1:0]        mstatus, mepc, mcause, mtval, mip;
    logic [2*W-1:0]      mcycle, minstret;
    logic [W-1:0]        cur_val, wmask, wdata;
    logic                read_ok, write_ok;
    csr_pkg::csr_wr_t    wr;
    trap_pkg::irq_code_e irq_cause;

    assign read_ok  = access_i.read && !access_i.kill;
    // Trap events in the same cycle win over the CSR write
    assign write_ok = access_i.write && !access_i.kill &&
                      !(trap_i.mret || trap_i.raise || trap_i.irq_ack);

    ////////////////////////////////////////////////////////////////////
    // Current value and mask by address
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        case (access_i.addr)
            csr_pkg::ADDR_MSTATUS:   begin cur_val = mstatus;   wmask = csr_pkg::MASK_MSTATUS; end
            csr_pkg::ADDR_MISA:      begin cur_val = csr_pkg::MISA_VALUE;
                                           wmask = csr_pkg::MASK_MISA; end
            csr_pkg::ADDR_MIE:       begin cur_val = mie_q;      wmask = csr_pkg::MASK_MIE; end
            csr_pkg::ADDR_MTVEC:     begin cur_val = mtvec_q;    wmask = csr_pkg::MASK_MTVEC; end
            csr_pkg::ADDR_MSCRATCH:  begin cur_val = mscratch_q; wmask = csr_pkg::MASK_FULL; end
            csr_pkg::ADDR_MEPC:      begin cur_val = mepc;       wmask = csr_pkg::MASK_MEPC; end
            csr_pkg::ADDR_MCAUSE:    begin cur_val = mcause;     wmask = csr_pkg::MASK_FULL; end
            csr_pkg::ADDR_MTVAL:     begin cur_val = mtval;      wmask = csr_pkg::MASK_FULL; end
            csr_pkg::ADDR_MCYCLE:    begin cur_val = mcycle[W-1:0];     wmask = csr_pkg::MASK_FULL; end
            csr_pkg::ADDR_MCYCLEH:   begin cur_val = mcycle[2*W-1:W];   wmask = csr_pkg::MASK_FULL; end
            csr_pkg::ADDR_MINSTRET:  begin cur_val = minstret[W-1:0];   wmask = csr_pkg::MASK_FULL; end
            csr_pkg::ADDR_MINSTRETH: begin cur_val = minstret[2*W-1:W]; wmask = csr_pkg::MASK_FULL; end
            default:                 begin cur_val = '0;         wmask = '0; end  // mip too
        endcase
    end

    always_comb begin
        case (access_i.op)
            csr_pkg::CSR_SET:   wdata = (cur_val | access_i.data) & wmask;
            csr_pkg::CSR_CLEAR: wdata = (cur_val & ~access_i.data) & wmask;
            default:            wdata = access_i.data & wmask;
        endcase
    end

    // Gated strobes, one per writable register
    always_comb begin
        wr           = '0;
        wr.data      = wdata;
        wr.mstatus   = write_ok && access_i.addr == csr_pkg::ADDR_MSTATUS;
        wr.mie       = write_ok && access_i.addr == csr_pkg::ADDR_MIE;
        wr.mtvec     = write_ok && access_i.addr == csr_pkg::ADDR_MTVEC;
        wr.mscratch  = write_ok && access_i.addr == csr_pkg::ADDR_MSCRATCH;
        wr.mepc      = write_ok && access_i.addr == csr_pkg::ADDR_MEPC;
        wr.mcause    = write_ok && access_i.addr == csr_pkg::ADDR_MCAUSE;
        wr.mtval     = write_ok && access_i.addr == csr_pkg::ADDR_MTVAL;
        wr.mcycle    = write_ok && access_i.addr == csr_pkg::ADDR_MCYCLE;
        wr.mcycleh   = write_ok && access_i.addr == csr_pkg::ADDR_MCYCLEH;
        wr.minstret  = write_ok && access_i.addr == csr_pkg::ADDR_MINSTRET;
        wr.minstreth = write_ok && access_i.addr == csr_pkg::ADDR_MINSTRETH;
    end

    // Registers with no trap side effects
    always_ff @(posedge clk) begin
        if (reset) begin
            mie_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
        end
        else begin
            if (wr.mie)      mie_q      <= wr.data;
            if (wr.mtvec)    mtvec_q    <= wr.data;
            if (wr.mscratch) mscratch_q <= wr.data;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Submodules
    ////////////////////////////////////////////////////////////////////
    csr_counter64 u_mcycle (
        .clk(clk), .reset(reset), .inc_i(1'b1),
        .wr_lo_i(wr.mcycle), .wr_hi_i(wr.mcycleh), .wdata_i(wr.data), .count_o(mcycle)
    );

    csr_counter64 u_minstret (
        .clk(clk), .reset(reset), .inc_i(!access_i.kill),   // Retired when not killed
        .wr_lo_i(wr.minstret), .wr_hi_i(wr.minstreth), .wdata_i(wr.data), .count_o(minstret)
    );

    irq_ctrl u_irq (
        .clk(clk), .reset(reset), .irq_i(irq_i), .mie_i(mie_q),
        .mstatus_mie_i(mstatus[csr_pkg::MSTATUS_MIE_BIT]), .ack_i(trap_i.irq_ack),
        .mip_o(mip), .pending_o(interrupt_pending_o), .cause_o(irq_cause)
    );

    trap_ctrl u_trap (
        .clk(clk), .reset(reset), .trap_i(trap_i), .wr_i(wr), .irq_cause_i(irq_cause),
        .mstatus_o(mstatus), .mepc_o(mepc), .mcause_o(mcause), .mtval_o(mtval),
        .privilege_o(privilege_o)
    );

    // Read port, zero when killed or unmapped
    always_comb begin
        rdata_o = '0;
        if (read_ok) begin
            if (access_i.addr == csr_pkg::ADDR_MIP) begin
                rdata_o = mip;
            end
            else begin
                rdata_o = cur_val;
            end
        end
    end

    assign mepc_o  = mepc;
    assign mtvec_o = mtvec_q;

endmodule

/* hdl/csr_counter64.sv */
//////////////////////////////////////////////////////////////////////
// 64-bit event counter with separately writable halves, used for
// mcycle and minstret
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module csr_counter64 (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         inc_i,
    input  logic                         wr_lo_i,
    input  logic                         wr_hi_i,
    input  logic [csr_pkg::XLEN-1:0]     wdata_i,
    output logic [2*csr_pkg::XLEN-1:0]   count_o
);

    localparam int W = csr_pkg::XLEN;

    logic [2*W-1:0] count_q;

    // A write takes the place of the increment in that cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
        end
        else if (wr_lo_i) begin
            count_q[W-1:0] <= wdata_i;
        end
        else if (wr_hi_i) begin
            count_q[2*W-1:W] <= wdata_i;
        end
        else if (inc_i) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign count_o = count_q;

endmodule

/* hdl/csr_pkg.sv */
//////////////////////////////////////////////////////////////////////
// CSR bank definitions: addresses, write masks, misa contents and
// the access and write-strobe structs shared by the bank modules
//////////////////////////////////////////////////////////////////////

package csr_pkg;

    localparam int XLEN = 32;

    // Machine-mode CSR addresses
    localparam logic [11:0] ADDR_MSTATUS   = 12'h300;
    localparam logic [11:0] ADDR_MISA      = 12'h301;
    localparam logic [11:0] ADDR_MIE       = 12'h304;
    localparam logic [11:0] ADDR_MTVEC     = 12'h305;
    localparam logic [11:0] ADDR_MSCRATCH  = 12'h340;
    localparam logic [11:0] ADDR_MEPC      = 12'h341;
    localparam logic [11:0] ADDR_MCAUSE    = 12'h342;
    localparam logic [11:0] ADDR_MTVAL     = 12'h343;
    localparam logic [11:0] ADDR_MIP       = 12'h344;
    localparam logic [11:0] ADDR_MCYCLE    = 12'hB00;
    localparam logic [11:0] ADDR_MINSTRET  = 12'hB02;
    localparam logic [11:0] ADDR_MCYCLEH   = 12'hB80;
    localparam logic [11:0] ADDR_MINSTRETH = 12'hB82;

    // Writable bits per register
    localparam logic [XLEN-1:0] MASK_MSTATUS = 32'h0000_1888;   // MPP, MPIE, MIE
    localparam logic [XLEN-1:0] MASK_MISA    = 32'h0000_0000;
    localparam logic [XLEN-1:0] MASK_MIE     = 32'h0000_0888;   // MEIE, MTIE, MSIE
    localparam logic [XLEN-1:0] MASK_MTVEC   = 32'hFFFF_FFFC;
    localparam logic [XLEN-1:0] MASK_MEPC    = 32'hFFFF_FFFC;
    localparam logic [XLEN-1:0] MASK_FULL    = 32'hFFFF_FFFF;

    // MXL = 1 (RV32), U and I extensions
    localparam logic [XLEN-1:0] MISA_VALUE   = 32'h4010_0100;

    // mstatus field positions
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;

    typedef enum logic [1:0] {
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_e;

    typedef struct packed {
        logic            read;
        logic            write;
        logic            kill;
        csr_op_e         op;
        logic [11:0]     addr;
        logic [XLEN-1:0] data;
    } csr_access_t;

    // Gated strobes, at most one high per cycle
    typedef struct packed {
        logic            mstatus;
        logic            mie;
        logic            mtvec;
        logic            mscratch;
        logic            mepc;
        logic            mcause;
        logic            mtval;
        logic            mcycle;
        logic            mcycleh;
        logic            minstret;
        logic            minstreth;
        logic [XLEN-1:0] data;      // Already masked and combined
    } csr_wr_t;

endpackage

/* hdl/irq_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// Interrupt sampling: registers the lines into mip, flags an enabled
// pending interrupt and picks its cause (external, software, timer)
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module irq_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [csr_pkg::XLEN-1:0]   irq_i,
    input  logic [csr_pkg::XLEN-1:0]   mie_i,
    input  logic                       mstatus_mie_i,
    input  logic                       ack_i,
    output logic [csr_pkg::XLEN-1:0]   mip_o,
    output logic                       pending_o,
    output trap_pkg::irq_code_e        cause_o
);

    logic [csr_pkg::XLEN-1:0] mip_q;
    logic [csr_pkg::XLEN-1:0] enabled;
    logic                     take;
    logic                     pending_q;
    trap_pkg::irq_code_e      cause_q;

    assign enabled = mie_i & mip_q;
    assign take    = mstatus_mie_i && (enabled != '0) && !ack_i;

    // One cycle of sampling on the raw lines
    always_ff @(posedge clk) begin
        if (reset) begin
            mip_q <= '0;
        end
        else begin
            mip_q <= irq_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_q <= 1'b0;
        end
        else begin
            pending_q <= take;   // Dropped in the ack cycle
        end
    end

    // Fixed priority, last cause held while idle
    always_ff @(posedge clk) begin
        if (take) begin
            if (enabled[trap_pkg::IRQ_MEI_BIT]) begin
                cause_q <= trap_pkg::M_EXT_INT;
            end
            else if (enabled[trap_pkg::IRQ_MSI_BIT]) begin
                cause_q <= trap_pkg::M_SW_INT;
            end
            else if (enabled[trap_pkg::IRQ_MTI_BIT]) begin
                cause_q <= trap_pkg::M_TIM_INT;
            end
        end
    end

    assign mip_o     = mip_q;
    assign pending_o = pending_q;
    assign cause_o   = cause_q;

endmodule

/* hdl/trap_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// Privilege FSM (machine/user) with the trap registers mstatus, mepc,
// mcause and mtval; handles exceptions, interrupt entry and mret
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module trap_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    input  trap_pkg::trap_req_t        trap_i,
    input  csr_pkg::csr_wr_t           wr_i,
    input  trap_pkg::irq_code_e        irq_cause_i,
    output logic [csr_pkg::XLEN-1:0]   mstatus_o,
    output logic [csr_pkg::XLEN-1:0]   mepc_o,
    output logic [csr_pkg::XLEN-1:0]   mcause_o,
    output logic [csr_pkg::XLEN-1:0]   mtval_o,
    output trap_pkg::priv_e            privilege_o
);

    localparam int W = csr_pkg::XLEN;

    trap_pkg::priv_e state_q, state_d;
    logic            mie_q, mpie_q;
    logic [1:0]      mpp_q;            // Raw bits, legalised on mret
    logic [W-1:0]    mepc_q, mcause_q, mtval_q;
    logic            pc_is_return;

    // ECALL and EBREAK return to the trapping instruction
    assign pc_is_return = (trap_i.exc_code == trap_pkg::ECALL_FROM_MMODE) ||
                          (trap_i.exc_code == trap_pkg::ECALL_FROM_UMODE) ||
                          (trap_i.exc_code == trap_pkg::BREAKPOINT);

    ////////////////////////////////////////////////////////////////////
    // Privilege state
    ////////////////////////////////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            trap_pkg::PRIV_MACHINE: begin
                if (trap_i.mret && mpp_q != trap_pkg::PRIV_MACHINE) begin
                    state_d = trap_pkg::PRIV_USER;
                end
            end
            default: begin
                if (trap_i.raise || trap_i.irq_ack) begin
                    state_d = trap_pkg::PRIV_MACHINE;
                end
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Trap registers, priority mret > exception > ack > CSR write
    ////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q  <= trap_pkg::PRIV_MACHINE;
            mie_q    <= 1'b0;
            mpie_q   <= 1'b0;
            mpp_q    <= 2'b00;
            mepc_q   <= '0;
            mcause_q <= '0;
            mtval_q  <= '0;
        end
        else begin
            state_q <= state_d;
            if (trap_i.mret) begin
                mie_q <= mpie_q;
            end
            else if (trap_i.raise) begin
                mpp_q    <= state_q;
                mpie_q   <= mie_q;
                mie_q    <= 1'b0;
                mcause_q <= {1'b0, {(W-6){1'b0}}, trap_i.exc_code};
                mepc_q   <= pc_is_return ? trap_i.pc : trap_i.pc + 32'd4;
                mtval_q  <= (trap_i.exc_code == trap_pkg::ILLEGAL_INSTRUCTION)
                            ? trap_i.instr : trap_i.pc;
            end
            else if (trap_i.irq_ack) begin
                mpp_q    <= state_q;
                mpie_q   <= mie_q;
                mie_q    <= 1'b0;
                mcause_q <= {1'b1, {(W-6){1'b0}}, irq_cause_i};
                mepc_q   <= trap_i.jump ? trap_i.jump_target : trap_i.pc;
            end
            else begin
                if (wr_i.mstatus) begin
                    mie_q  <= wr_i.data[csr_pkg::MSTATUS_MIE_BIT];
                    mpie_q <= wr_i.data[csr_pkg::MSTATUS_MPIE_BIT];
                    mpp_q  <= wr_i.data[csr_pkg::MSTATUS_MPP_LSB +: 2];
                end
                if (wr_i.mepc)   mepc_q   <= wr_i.data;
                if (wr_i.mcause) mcause_q <= wr_i.data;
                if (wr_i.mtval)  mtval_q  <= wr_i.data;
            end
        end
    end

    always_comb begin
        mstatus_o = '0;
        mstatus_o[csr_pkg::MSTATUS_MIE_BIT]       = mie_q;
        mstatus_o[csr_pkg::MSTATUS_MPIE_BIT]      = mpie_q;
        mstatus_o[csr_pkg::MSTATUS_MPP_LSB +: 2]  = mpp_q;
    end

    assign mepc_o      = mepc_q;
    assign mcause_o    = mcause_q;
    assign mtval_o     = mtval_q;
    assign privilege_o = state_q;

endmodule

/* hdl/trap_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Trap definitions: privilege levels, exception and interrupt cause
// codes, and the trap request driven by the core pipeline
//////////////////////////////////////////////////////////////////////

package trap_pkg;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_e;

    typedef enum logic [4:0] {
        INSTR_MISALIGNED    = 5'd0,
        INSTR_ACCESS_FAULT  = 5'd1,
        ILLEGAL_INSTRUCTION = 5'd2,
        BREAKPOINT          = 5'd3,
        LOAD_MISALIGNED     = 5'd4,
        LOAD_ACCESS_FAULT   = 5'd5,
        STORE_MISALIGNED    = 5'd6,
        STORE_ACCESS_FAULT  = 5'd7,
        ECALL_FROM_UMODE    = 5'd8,
        ECALL_FROM_MMODE    = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        M_SW_INT  = 5'd3,
        M_TIM_INT = 5'd7,
        M_EXT_INT = 5'd11
    } irq_code_e;

    // Bit positions in mip and mie
    localparam int IRQ_MSI_BIT = 3;
    localparam int IRQ_MTI_BIT = 7;
    localparam int IRQ_MEI_BIT = 11;

    typedef struct packed {
        logic                     raise;        // Exception
        logic                     mret;
        logic                     irq_ack;
        exc_code_e                exc_code;
        logic [csr_pkg::XLEN-1:0] pc;
        logic [csr_pkg::XLEN-1:0] instr;
        logic                     jump;         // Branch taken at interrupt
        logic [csr_pkg::XLEN-1:0] jump_target;
    } trap_req_t;

endpackage

/* run.sh */
#!/bin/sh
# Compile the CSR bank testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module csr_bank_tb -f files.f
out=$(./obj_dir/Vcsr_bank_tb)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

/* verif/csr_bank_asserts.sv */
//////////////////////////////////////////////////////////////////////
// Concurrent checks on the interrupt and privilege outputs, bound
// into every csr_bank instance
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module csr_bank_asserts (
    input  logic                clk,
    input  logic                reset,
    input  trap_pkg::trap_req_t trap_i,
    input  logic                pending_i,
    input  trap_pkg::priv_e     privilege_i
);

    // An acknowledged interrupt is not flagged again next cycle
    ack_clears_pending: assert property (@(posedge clk) disable iff (reset)
        trap_i.irq_ack |=> !pending_i)
        else $error("interrupt still pending in the cycle after its acknowledge");

    reset_clears_pending: assert property (@(posedge clk)
        reset |=> !pending_i)
        else $error("interrupt pending while reset is held");

    privilege_legal: assert property (@(posedge clk) disable iff (reset)
        privilege_i == trap_pkg::PRIV_USER || privilege_i == trap_pkg::PRIV_MACHINE)
        else $error("privilege level is neither user nor machine");

endmodule

bind csr_bank csr_bank_asserts u_asserts (
    .clk(clk), .reset(reset), .trap_i(trap_i),
    .pending_i(interrupt_pending_o), .privilege_i(privilege_o)
);

/* verif/csr_bank_tb.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the CSR bank: CSR access operations, kill, traps,
// interrupt entry and the 64-bit counters, checked against a model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module csr_bank_tb;

    localparam int R_MSCRATCH = 0;
    localparam int R_MTVEC    = 1;
    localparam int R_MIE      = 2;
    localparam int R_MEPC     = 3;
    localparam int R_MSTATUS  = 4;
    localparam int N_GAP      = 10;
    localparam int MAX_CYCLES = 2000;   // Tests need about 150 cycles
    localparam logic [31:0] MISA_EXP = 32'h4010_0100;   // MXL 1 with U and I bits

    logic                 clk = 1'b0;
    logic                 reset;
    csr_pkg::csr_access_t access;
    trap_pkg::trap_req_t  req;
    logic [31:0]          irq, rdata, mepc_out, mtvec_out;
    logic                 pending;
    trap_pkg::priv_e      privilege;

    logic [11:0] reg_addr [5];
    logic [31:0] reg_mask [5];
    logic [31:0] model [5];                  // Expected register contents
    string       reg_name [5];
    logic [31:0] m_mcause, m_mtval, rng;
    logic [1:0]  m_priv;
    logic        chk_en;
    logic [31:0] chk_exp;
    string       chk_name;
    int          errors, checks, cycle_count;

    csr_bank UUT (
        .clk(clk), .reset(reset), .access_i(access), .trap_i(req), .irq_i(irq),
        .rdata_o(rdata), .interrupt_pending_o(pending), .privilege_o(privilege),
        .mepc_o(mepc_out), .mtvec_o(mtvec_out)
    );

    always #10 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////
    function automatic logic [31:0] csr_expect(input logic [31:0] old,
                                               input csr_pkg::csr_op_e op,
                                               input logic [31:0] data,
                                               input logic [31:0] mask);
        case (op)
            csr_pkg::CSR_SET:   return (old | data) & mask;
            csr_pkg::CSR_CLEAR: return old & ~data & mask;
            default:            return data & mask;
        endcase
    endfunction

    // Trap entry on mstatus: MPP <- priv, MPIE <- MIE, MIE <- 0
    function automatic logic [31:0] trap_status(input logic [31:0] old, input logic [1:0] priv);
        logic [31:0] s;
        s        = old;
        s[12:11] = priv;
        s[7]     = old[3];
        s[3]     = 1'b0;
        return s;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic csr_pkg::csr_op_e pick_op(input logic [31:0] r);
        case (r % 3)
            0:       return csr_pkg::CSR_WRITE;
            1:       return csr_pkg::CSR_SET;
            default: return csr_pkg::CSR_CLEAR;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus tasks, entered and left 2 ns after a rising edge
    //////////////////////////////////////////////////////////////////////
    task automatic write_access(input csr_pkg::csr_op_e op, input logic [11:0] addr,
                                input logic [31:0] data, input logic kill);
        access       = '0;
        access.write = 1'b1;
        access.kill  = kill;
        access.op    = op;
        access.addr  = addr;
        access.data  = data;
        @(posedge clk);
        #2;
        access = '0;
    endtask

    task automatic read_check(input logic [11:0] addr, input logic [31:0] exp,
                              input string name, input logic kill);
        access      = '0;
        access.read = 1'b1;
        access.kill = kill;
        access.addr = addr;
        chk_exp     = exp;
        chk_name    = name;
        chk_en      = 1'b1;       // Compared on the falling edge
        @(posedge clk);
        #2;
        chk_en = 1'b0;
        access = '0;
    endtask

    task automatic read_sample(input logic [11:0] addr, output logic [31:0] val);
        access      = '0;
        access.read = 1'b1;
        access.addr = addr;
        #8;
        val = rdata;
        @(posedge clk);
        #2;
        access = '0;
    endtask

    task automatic apply_trap();
        @(posedge clk);
        #2;
        req = '0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch at %0t: %s is %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic write_and_verify(input int idx, input csr_pkg::csr_op_e op,
                                    input logic [31:0] data);
        write_access(op, reg_addr[idx], data, 1'b0);
        model[idx] = csr_expect(model[idx], op, data, reg_mask[idx]);
        read_check(reg_addr[idx], model[idx], reg_name[idx], 1'b0);
    endtask

    task automatic verify_trap_regs();
        read_check(csr_pkg::ADDR_MSTATUS, model[R_MSTATUS], "mstatus", 1'b0);
        read_check(csr_pkg::ADDR_MEPC, model[R_MEPC], "mepc", 1'b0);
        read_check(csr_pkg::ADDR_MCAUSE, m_mcause, "mcause", 1'b0);
        read_check(csr_pkg::ADDR_MTVAL, m_mtval, "mtval", 1'b0);
        check_value(mepc_out, model[R_MEPC], "mepc_o");
        check_value({30'b0, privilege}, {30'b0, m_priv}, "privilege_o");
    endtask

    // Read port comparison
    always @(negedge clk) begin
        if (chk_en) begin
            checks++;
            assert (rdata === chk_exp) else begin
                errors++;
                $display("Mismatch at %0t: %s read %08h, expected %08h",
                         $time, chk_name, rdata, chk_exp);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run not finished after %0d cycles, %0d checks, %0d errors",
                     MAX_CYCLES, checks, errors);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        int          idx;
        int          n;
        logic [31:0] v0, v1;
        csr_pkg::csr_op_e op;

        reset  = 1'b1;
        access = '0;
        req    = '0;
        irq    = '0;
        chk_en = 1'b0;
        rng    = 32'h29b9_0f89;
        reg_addr = '{csr_pkg::ADDR_MSCRATCH, csr_pkg::ADDR_MTVEC, csr_pkg::ADDR_MIE,
                     csr_pkg::ADDR_MEPC, csr_pkg::ADDR_MSTATUS};
        reg_mask = '{32'hFFFF_FFFF, 32'hFFFF_FFFC, 32'h0000_0888, 32'hFFFF_FFFC, 32'h0000_1888};
        reg_name = '{"mscratch", "mtvec", "mie", "mepc", "mstatus"};
        model    = '{default: 32'h0};
        m_mcause = '0;
        m_mtval  = '0;
        m_priv   = trap_pkg::PRIV_MACHINE;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        read_check(csr_pkg::ADDR_MISA, MISA_EXP, "misa after reset", 1'b0);
        check_value({31'b0, pending}, 32'h0, "pending after reset");
        verify_trap_regs();

        // Random accesses to the plain registers
        for (int i = 0; i < 40; i++) begin
            rng = xorshift32(rng);
            idx = int'(rng % 32'd5);
            rng = xorshift32(rng);
            op  = pick_op(rng);
            rng = xorshift32(rng);
            write_and_verify(idx, op, rng);
        end
        check_value(mtvec_out, model[R_MTVEC], "mtvec_o");
        write_access(csr_pkg::CSR_WRITE, csr_pkg::ADDR_MISA, 32'hFFFF_FFFF, 1'b0);
        read_check(csr_pkg::ADDR_MISA, MISA_EXP, "misa after write", 1'b0);

        // Killed accesses and an unmapped address
        rng = xorshift32(rng);
        write_access(csr_pkg::CSR_WRITE, csr_pkg::ADDR_MSCRATCH, rng, 1'b1);
        read_check(csr_pkg::ADDR_MSCRATCH, model[R_MSCRATCH], "mscratch after kill", 1'b0);
        read_check(csr_pkg::ADDR_MSCRATCH, 32'h0, "killed read", 1'b1);
        read_check(12'h7C0, 32'h0, "unmapped read", 1'b0);

        //////////////////////////////////////////////////////////////////
        // Exceptions and mret
        //////////////////////////////////////////////////////////////////
        write_and_verify(R_MSTATUS, csr_pkg::CSR_WRITE, 32'h0000_0008);
        req          = '0;
        req.raise    = 1'b1;
        req.exc_code = trap_pkg::ECALL_FROM_MMODE;
        req.pc       = 32'h1000_0040;
        req.instr    = 32'h0000_0073;
        apply_trap();
        model[R_MSTATUS] = trap_status(model[R_MSTATUS], m_priv);
        model[R_MEPC]    = 32'h1000_0040;           // ECALL returns to itself
        m_mcause         = 32'd11;
        m_mtval          = 32'h1000_0040;
        m_priv           = trap_pkg::PRIV_MACHINE;
        verify_trap_regs();

        rng          = xorshift32(rng);
        req          = '0;
        req.raise    = 1'b1;
        req.exc_code = trap_pkg::ILLEGAL_INSTRUCTION;
        req.pc       = 32'h1000_0104;
        req.instr    = rng;
        apply_trap();
        model[R_MSTATUS] = trap_status(model[R_MSTATUS], m_priv);
        model[R_MEPC]    = 32'h1000_0108;
        m_mcause         = 32'd2;
        m_mtval          = rng;                     // Faulting instruction word
        verify_trap_regs();

        write_and_verify(R_MSTATUS, csr_pkg::CSR_WRITE, 32'h0000_0080);   // MPP user, MPIE on
        req      = '0;
        req.mret = 1'b1;
        apply_trap();
        m_priv              = model[R_MSTATUS][12:11];
        model[R_MSTATUS][3] = model[R_MSTATUS][7];
        verify_trap_regs();

        //////////////////////////////////////////////////////////////////
        // Interrupt entry from user mode
        //////////////////////////////////////////////////////////////////
        write_and_verify(R_MIE, csr_pkg::CSR_WRITE, 32'h0000_0880);
        irq[11] = 1'b1;                             // External and timer together
        irq[7]  = 1'b1;
        n = 0;
        while (!pending && n < 2) begin
            @(posedge clk);
            #2;
            n++;
        end
        check_value({31'b0, pending}, 32'h1, "pending two cycles after irq");
        req             = '0;
        req.irq_ack     = 1'b1;
        req.pc          = 32'h1000_0200;
        req.jump        = 1'b1;
        req.jump_target = 32'h0000_3A10;
        apply_trap();
        irq              = '0;
        model[R_MSTATUS] = trap_status(model[R_MSTATUS], m_priv);
        model[R_MEPC]    = 32'h0000_3A10;
        m_mcause         = 32'h8000_000B;
        m_priv           = trap_pkg::PRIV_MACHINE;
        check_value({31'b0, pending}, 32'h0, "pending after ack");
        verify_trap_regs();

        // Counters
        read_sample(csr_pkg::ADDR_MCYCLE, v0);
        wait_cycles(N_GAP - 1);
        read_sample(csr_pkg::ADDR_MCYCLE, v1);
        check_value(v1 - v0, N_GAP, "mcycle delta");
        rng = xorshift32(rng);
        write_access(csr_pkg::CSR_WRITE, csr_pkg::ADDR_MCYCLEH, rng, 1'b0);
        read_check(csr_pkg::ADDR_MCYCLEH, rng, "mcycleh", 1'b0);
        read_sample(csr_pkg::ADDR_MINSTRET, v0);
        access.kill = 1'b1;
        wait_cycles(5);
        access = '0;
        read_sample(csr_pkg::ADDR_MINSTRET, v1);
        check_value(v1 - v0, 32'd1, "minstret delta over killed cycles");

        $display("Finished: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
